// File: verilog/md_pkg.sv
// Multiply divide unit definitions
`default_nettype none

package md_pkg;

    localparam int XLEN  = 32;   // Operand width
    localparam int STEPS = 32;   // One step per operand bit
    localparam int CNT_W = 6;    // Must hold STEPS itself

    // Operation codes seen at the unit's start strobe
    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_MULT  = 3'd1,
        OP_MULTU = 3'd2,
        OP_DIV   = 3'd3,
        OP_DIVU  = 3'd4,
        OP_MTHI  = 3'd5,
        OP_MTLO  = 3'd6
    } md_op_t;

    // Unsigned magnitudes handed to both cores
    typedef struct packed {
        logic [XLEN-1:0] mag_a;   // Multiplicand or dividend
        logic [XLEN-1:0] mag_b;   // Multiplier or divisor
    } md_operands_t;

    // Product halves, or remainder and quotient
    typedef struct packed {
        logic [XLEN-1:0] hi;      // Upper product or remainder
        logic [XLEN-1:0] lo;      // Lower product or quotient
    } md_result_t;

endpackage

`default_nettype wire

// File: verilog/md_mul_core.sv
// Shift-add multiplier core
`timescale 1ns/100ps
`default_nettype none

module md_mul_core import md_pkg::*; (
    input  logic         CLK,
    input  logic         RST_X,
    input  logic         start,
    input  md_operands_t operands,
    output md_result_t   product,
    output logic         busy
);
    logic [XLEN-1:0]   multiplicand;
    logic [2*XLEN-1:0] acc;          // Partial product over multiplier
    logic [CNT_W-1:0]  count;
    logic [XLEN:0]     sum;

    assign busy    = (count < CNT_W'(STEPS));
    assign sum     = {1'b0, acc[2*XLEN-1:XLEN]} + {1'b0, multiplicand};
    assign product = md_result_t'(acc);

    // Counter idles at STEPS
    always_ff @(posedge CLK or negedge RST_X) begin
        if (!RST_X) begin
            count <= CNT_W'(STEPS);
        end else if (start) begin
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            multiplicand <= operands.mag_a;
            acc          <= {{XLEN{1'b0}}, operands.mag_b};
        end else if (busy) begin
            if (acc[0]) begin
                acc <= {sum, acc[XLEN-1:1]};     // Add then shift
            end else begin
                acc <= {1'b0, acc[2*XLEN-1:1]};
            end
        end
    end

    // Outside logic must wait for busy to drop
    assert property (@(posedge CLK) disable iff (!RST_X) start |-> !busy)
        else $error("md_mul_core: start while busy");

endmodule

`default_nettype wire

// File: verilog/md_div_core.sv
// Restoring divider core
`timescale 1ns/100ps
`default_nettype none

module md_div_core import md_pkg::*; (
    input  logic         CLK,
    input  logic         RST_X,
    input  logic         start,
    input  md_operands_t operands,
    output md_result_t   quot_rem,
    output logic         busy
);
    logic [XLEN-1:0]   divisor;
    logic [2*XLEN-1:0] rq;           // Remainder high, quotient low
    logic [CNT_W-1:0]  count;
    logic [XLEN:0]     upper;        // Remainder with next dividend bit
    logic [XLEN:0]     diff;
    logic              fits;

    assign busy     = (count < CNT_W'(STEPS));
    assign upper    = rq[2*XLEN-1:XLEN-1];
    assign diff     = upper - {1'b0, divisor};
    assign fits     = (upper >= {1'b0, divisor});
    assign quot_rem = md_result_t'(rq);

    always_ff @(posedge CLK or negedge RST_X) begin
        if (!RST_X) begin
            count <= CNT_W'(STEPS);
        end else if (start) begin
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
        end
    end

    // One quotient bit per step
    always_ff @(posedge CLK) begin
        if (start) begin
            divisor <= operands.mag_b;
            rq      <= {{XLEN{1'b0}}, operands.mag_a};
        end else if (busy) begin
            if (fits) begin
                rq <= {diff[XLEN-1:0], rq[XLEN-2:0], 1'b1};   // Subtract kept
            end else begin
                rq <= {rq[2*XLEN-2:0], 1'b0};                  // Restore
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/md_sign_fix.sv
// Operand sign handling and result fix-up
`timescale 1ns/100ps
`default_nettype none

module md_sign_fix import md_pkg::*; (
    input  logic            CLK,
    input  logic            RST_X,
    input  logic            start,
    input  md_op_t          op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic            core_start,
    output md_operands_t    operands,
    input  md_result_t      mul_raw,
    input  md_result_t      div_raw,
    input  logic            mul_busy,
    input  logic            div_busy,
    output logic            busy,
    output md_result_t      result,
    output logic            finish
);
    logic              is_arith;
    logic              is_signed;
    logic              is_div_q;
    logic              signed_q;
    logic              sign_a_q;
    logic              sign_b_q;
    logic              zero_div_q;
    logic              busy_q;
    logic              neg_diff;     // Operand signs differ
    logic              neg_rem;
    logic [2*XLEN-1:0] prod;

    assign is_arith   = (op == OP_MULT) || (op == OP_MULTU) ||
                        (op == OP_DIV) || (op == OP_DIVU);
    assign is_signed  = (op == OP_MULT) || (op == OP_DIV);
    assign core_start = start && is_arith;

    assign operands.mag_a = (is_signed && a[XLEN-1]) ? -a : a;
    assign operands.mag_b = (is_signed && b[XLEN-1]) ? -b : b;

    always_ff @(posedge CLK or negedge RST_X) begin
        if (!RST_X) begin
            is_div_q   <= 1'b0;
            signed_q   <= 1'b0;
            sign_a_q   <= 1'b0;
            sign_b_q   <= 1'b0;
            zero_div_q <= 1'b0;
        end else if (core_start) begin
            is_div_q   <= (op == OP_DIV) || (op == OP_DIVU);
            signed_q   <= is_signed;
            sign_a_q   <= a[XLEN-1];
            sign_b_q   <= b[XLEN-1];
            zero_div_q <= (b == '0);
        end
    end

    assign busy = is_div_q ? div_busy : mul_busy;

    // Finish one cycle after the falling edge of busy
    always_ff @(posedge CLK or negedge RST_X) begin
        if (!RST_X) begin
            busy_q <= 1'b0;
            finish <= 1'b0;
        end else begin
            busy_q <= busy;
            finish <= busy_q && !busy;
        end
    end

    assign neg_diff = signed_q && (sign_a_q ^ sign_b_q);
    assign neg_rem  = signed_q && sign_a_q;    // Remainder follows dividend
    assign prod     = {mul_raw.hi, mul_raw.lo};

    always_comb begin
        if (!is_div_q) begin
            result = neg_diff ? md_result_t'(-prod) : mul_raw;
        end else if (zero_div_q) begin
            result = '0;
        end else begin
            result.hi = neg_rem ? -div_raw.hi : div_raw.hi;
            result.lo = neg_diff ? -div_raw.lo : div_raw.lo;
        end
    end

endmodule

`default_nettype wire

// File: verilog/md_hilo.sv
// HI and LO registers
`timescale 1ns/100ps
`default_nettype none

module md_hilo import md_pkg::*; (
    input  logic            CLK,
    input  logic            RST_X,
    input  logic            start,
    input  md_op_t          op,
    input  logic [XLEN-1:0] a,
    input  md_result_t      result,
    input  logic            finish,
    output logic [XLEN-1:0] hi,
    output logic [XLEN-1:0] lo
);
    logic [XLEN-1:0] hi_q;
    logic [XLEN-1:0] lo_q;
    logic            mthi;
    logic            mtlo;

    assign mthi = start && (op == OP_MTHI);
    assign mtlo = start && (op == OP_MTLO);

    always_ff @(posedge CLK or negedge RST_X) begin
        if (!RST_X) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (finish) begin
            hi_q <= result.hi;
            lo_q <= result.lo;
        end else begin
            if (mthi) hi_q <= a;
            if (mtlo) lo_q <= a;
        end
    end

    // Result visible during finish before the register loads
    assign hi = finish ? result.hi : hi_q;
    assign lo = finish ? result.lo : lo_q;

    assert property (@(posedge CLK) disable iff (!RST_X) finish |-> !(mthi || mtlo))
        else $error("md_hilo: MTHI/MTLO collides with operation end");

endmodule

`default_nettype wire

// File: verilog/md_unit.sv
// Multiply divide unit top
`timescale 1ns/100ps
`default_nettype none

module md_unit import md_pkg::*; (
    input  logic            CLK,
    input  logic            RST_X,
    input  logic            start,
    input  md_op_t          op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic            busy,
    output logic            done,
    output logic [XLEN-1:0] hi,
    output logic [XLEN-1:0] lo
);
    logic         core_start;
    md_operands_t operands;
    md_result_t   mul_raw;
    md_result_t   div_raw;
    logic         mul_busy;
    logic         div_busy;
    md_result_t   result;

    md_sign_fix u_sign_fix (
        .CLK        (CLK),
        .RST_X      (RST_X),
        .start      (start),
        .op         (op),
        .a          (a),
        .b          (b),
        .core_start (core_start),
        .operands   (operands),
        .mul_raw    (mul_raw),
        .div_raw    (div_raw),
        .mul_busy   (mul_busy),
        .div_busy   (div_busy),
        .busy       (busy),
        .result     (result),
        .finish     (done)          // Finish doubles as done
    );

    md_mul_core u_mul (
        .CLK      (CLK),
        .RST_X    (RST_X),
        .start    (core_start),
        .operands (operands),
        .product  (mul_raw),
        .busy     (mul_busy)
    );

    md_div_core u_div (
        .CLK      (CLK),
        .RST_X    (RST_X),
        .start    (core_start),
        .operands (operands),
        .quot_rem (div_raw),
        .busy     (div_busy)
    );

    md_hilo u_hilo (
        .CLK    (CLK),
        .RST_X  (RST_X),
        .start  (start),
        .op     (op),
        .a      (a),
        .result (result),
        .finish (done),
        .hi     (hi),
        .lo     (lo)
    );

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
// Testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic CLK,
    output logic RST_X
);
    initial begin
        CLK   = 1'b0;
        RST_X = 1'b0;
        repeat (2) @(posedge CLK);
        #10;
        RST_X = 1'b1;            // Released after two edges
    end

    always #50 CLK = ~CLK;       // 100 ns period

endmodule

`default_nettype wire

// File: tb/tb_md_unit.sv
// Multiply divide unit testbench
`timescale 1ns/100ps
`default_nettype none

module tb_md_unit import md_pkg::*; ();
    logic            CLK;
    logic            RST_X;
    logic            start;
    md_op_t          op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            busy;
    logic            done;
    logic [XLEN-1:0] hi;
    logic [XLEN-1:0] lo;

    logic [XLEN-1:0] exp_hi;     // HI as the model tracks it
    logic [XLEN-1:0] exp_lo;
    int              seed;
    logic [XLEN-1:0] corner [4];

    tb_clock u_clock (
        .CLK   (CLK),
        .RST_X (RST_X)
    );

    md_unit uut (
        .CLK   (CLK),
        .RST_X (RST_X),
        .start (start),
        .op    (op),
        .a     (a),
        .b     (b),
        .busy  (busy),
        .done  (done),
        .hi    (hi),
        .lo    (lo)
    );

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // Drive point just after the rising edge
    task automatic next_cycle();
        @(posedge CLK);
        #10;
    endtask

    // MIPS results from 64-bit arithmetic
    function automatic md_result_t model_result(input md_op_t kind,
                                                input logic [XLEN-1:0] x,
                                                input logic [XLEN-1:0] y);
        longint          sx;
        longint          sy;
        longint          q;
        longint          r;
        longint unsigned ux;
        longint unsigned uy;
        md_result_t      res;
        sx  = $signed(x);
        sy  = $signed(y);
        ux  = {32'h0, x};
        uy  = {32'h0, y};
        res = '0;
        case (kind)
            OP_MULT:  res = md_result_t'(sx * sy);
            OP_MULTU: res = md_result_t'(ux * uy);
            OP_DIV: begin
                if (y != '0) begin
                    q      = sx / sy;    // Truncates toward zero
                    r      = sx % sy;    // Sign of the dividend
                    res.hi = r[XLEN-1:0];
                    res.lo = q[XLEN-1:0];
                end
            end
            OP_DIVU: begin
                if (y != '0) begin
                    q      = longint'(ux / uy);
                    r      = longint'(ux % uy);
                    res.hi = r[XLEN-1:0];
                    res.lo = q[XLEN-1:0];
                end
            end
            default: res = '0;
        endcase
        return res;
    endfunction

    task automatic run_arith(input md_op_t kind, input logic [XLEN-1:0] opa,
                             input logic [XLEN-1:0] opb);
        md_result_t want;
        int         busy_cycles;
        int         gap;
        want        = model_result(kind, opa, opb);
        busy_cycles = 0;
        gap         = 0;
        next_cycle();
        start = 1'b1;
        op    = kind;
        a     = opa;
        b     = opb;
        next_cycle();
        start = 1'b0;
        op    = OP_NONE;
        while (busy) begin
            assert (!done)
                else stop_run($sformatf("FAIL %0t: done while busy", $time));
            busy_cycles++;
            if (busy_cycles > STEPS + 4) stop_run("Timeout: busy never went low");
            next_cycle();
        end
        assert (busy_cycles == STEPS)
            else stop_run($sformatf("FAIL %0t: busy high for %0d cycles", $time, busy_cycles));
        while (!done) begin
            gap++;
            if (gap > 4) stop_run("Timeout: no done pulse after busy went low");
            next_cycle();
        end
        assert (gap == 1)
            else stop_run($sformatf("FAIL %0t: done came %0d cycles after busy", $time, gap));
        assert (hi == want.hi && lo == want.lo)
            else stop_run($sformatf("FAIL %0t: %s %h %h gave hi %h lo %h, expected %h %h",
                $time, kind.name(), opa, opb, hi, lo, want.hi, want.lo));
        next_cycle();
        assert (!done)
            else stop_run($sformatf("FAIL %0t: done longer than one cycle", $time));
        assert (hi == want.hi && lo == want.lo)
            else stop_run($sformatf("FAIL %0t: %s result not held in HI/LO", $time, kind.name()));
        exp_hi = want.hi;
        exp_lo = want.lo;
    endtask

    task automatic run_move(input md_op_t kind, input logic [XLEN-1:0] val);
        next_cycle();
        start = 1'b1;
        op    = kind;
        a     = val;
        next_cycle();
        start = 1'b0;
        op    = OP_NONE;
        if (kind == OP_MTHI) begin
            exp_hi = val;
        end else begin
            exp_lo = val;
        end
        assert (hi == exp_hi && lo == exp_lo)
            else stop_run($sformatf("FAIL %0t: %s gave hi %h lo %h, expected %h %h",
                $time, kind.name(), hi, lo, exp_hi, exp_lo));
        assert (!busy && !done)
            else stop_run($sformatf("FAIL %0t: %s raised busy or done", $time, kind.name()));
    endtask

    initial begin
        int              guard;
        int              shift;
        logic [XLEN-1:0] x;
        logic [XLEN-1:0] y;
        seed   = 5088;
        start  = 1'b0;
        op     = OP_NONE;
        a      = '0;
        b      = '0;
        exp_hi = '0;
        exp_lo = '0;
        corner = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};
        guard  = 0;
        while (RST_X !== 1'b1) begin
            guard++;
            if (guard > 10) stop_run("Timeout: reset was never released");
            @(posedge CLK);
        end
        next_cycle();
        assert (!busy && !done && hi == '0 && lo == '0)
            else stop_run($sformatf("FAIL %0t: unit not idle and clear after reset", $time));

        run_move(OP_MTHI, 32'h1234_5678);
        run_move(OP_MTLO, 32'h9abc_def0);

        foreach (corner[i]) begin
            foreach (corner[j]) begin
                run_arith(OP_MULT, corner[i], corner[j]);
                run_arith(OP_MULTU, corner[i], corner[j]);
                run_arith(OP_DIV, corner[i], corner[j]);
                run_arith(OP_DIVU, corner[i], corner[j]);
            end
        end

        for (int i = 0; i < 20; i++) begin
            run_arith(OP_MULT, $random(seed), $random(seed));
            run_arith(OP_MULTU, $random(seed), $random(seed));
        end

        // Sign pattern follows the two low bits of the index
        for (int i = 0; i < 40; i++) begin
            x             = $random(seed);
            y             = $random(seed);
            shift         = $unsigned($random(seed)) % 31;
            y             = y >> shift;
            x[XLEN-1]     = 1'b0;
            y[XLEN-1]     = 1'b0;
            if (i[0]) x = -x;
            if (i[1]) y = -y;
            run_arith(OP_DIV, x, y);
            run_arith(OP_DIVU, x, y);
        end

        run_arith(OP_DIV, 32'hffff_fff9, 32'h0);     // Zero divisor
        run_arith(OP_DIVU, 32'h0000_0007, 32'h0);
        run_move(OP_MTLO, 32'h0bad_cafe);
        run_move(OP_MTHI, 32'h7654_3210);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
verilog/md_pkg.sv
verilog/md_mul_core.sv
verilog/md_div_core.sv
verilog/md_sign_fix.sv
verilog/md_hilo.sv
verilog/md_unit.sv
tb/tb_clock.sv
tb/tb_md_unit.sv

// File: Makefile
# Verilator flow for the multiply/divide unit

TOP = tb_md_unit

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps -Wno-fatal \
		-f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		-f vlog.f --top-module $(TOP) -o $(TOP)_sim
	@out="$$(./obj_dir/$(TOP)_sim 2>&1)"; \
		echo "$$out"; \
		echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
